// File: build.f
rtl/rgmii_pkg.sv
rtl/rgmii_lane_if.sv
rtl/rgmii_tx_encode.sv
rtl/rgmii_ddr_lane.sv
rtl/rgmii_rx_decode.sv
rtl/rgmii_phy_if.sv
sim/tb_clock_gen.sv
sim/tb_rgmii_phy_if.sv

// File: rtl/rgmii_ddr_lane.sv
module rgmii_ddr_lane import rgmii_pkg::*; #(
    parameter int                   LANE         = 0,
    parameter bit                   USE_IDELAY   = 1'b0,
    parameter logic [TAP_WIDTH-1:0] IDELAY_VALUE = '0
) (
    input  logic                 tx_clk_i,
    input  logic                 rx_clk_i,
    input  logic                 clk_div_i,
    input  logic                 rst_i,
    rgmii_lane_if.lane           lanes,
    output logic                 pin_o,
    input  logic                 pin_i,
    input  logic                 tap_load_i,
    input  logic [TAP_WIDTH-1:0] tap_value_i,
    output logic [TAP_WIDTH-1:0] tap_value_o
);

    // capture stage, one flop per clock edge
    logic rise_d;
    logic fall_d;

    // aligned stage, both halves on the rising edge
    logic rise_q;
    logic fall_q;

    // same-edge ddr output
    // rise half while the clock is high, fall half while low
    assign pin_o = tx_clk_i ? lanes.tx_rise[LANE] : lanes.tx_fall[LANE];

    // rising half of the pin
    always_ff @(posedge rx_clk_i)
    begin
        rise_d <= pin_i;
    end

    // falling half of the pin
    always_ff @(negedge rx_clk_i)
    begin
        fall_d <= pin_i;
    end

    // re-register both halves so they leave together
    // pipelined same-edge capture, one full rx cycle of latency
    always_ff @(posedge rx_clk_i)
    begin
        if (rst_i)
        begin
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end
        else
        begin
            rise_q <= rise_d;
            fall_q <= fall_d;
        end
    end

    // drive only this lane's bit
    assign lanes.rx_rise[LANE] = rise_q;
    assign lanes.rx_fall[LANE] = fall_q;

    generate
        if (USE_IDELAY)
        begin : g_tap
            // loadable tap counter, delay itself not modelled
            logic [TAP_WIDTH-1:0] tap_q;

            always_ff @(posedge clk_div_i)
            begin
                if (rst_i)
                begin
                    tap_q <= IDELAY_VALUE;
                end
                else if (tap_load_i)
                begin
                    tap_q <= tap_value_i;
                end
            end

            // readback reflects the load after the edge
            assign tap_value_o = tap_q;
        end
        else
        begin : g_no_tap
            // no delay element, pin path is a bare wire
            assign tap_value_o = '0;
        end
    endgenerate

    // loads while in reset would be lost silently
    a_no_load_in_reset : assert property (
        @(posedge clk_div_i) rst_i |-> !tap_load_i
    );

endmodule

// File: rtl/rgmii_lane_if.sv
interface rgmii_lane_if import rgmii_pkg::*; ();

    // transmit halves, one bit per lane
    // rise half goes out while the tx clock is high
    logic [NUM_LANES-1:0] tx_rise;
    logic [NUM_LANES-1:0] tx_fall;

    // receive halves, already aligned to the rx rising edge
    logic [NUM_LANES-1:0] rx_rise;
    logic [NUM_LANES-1:0] rx_fall;

    // encoder side
    modport enc (
        output tx_rise,
        output tx_fall
    );

    // each pin lane touches only its own bit
    modport lane (
        input  tx_rise,
        input  tx_fall,
        output rx_rise,
        output rx_fall
    );

    // decoder side
    modport dec (
        input  rx_rise,
        input  rx_fall
    );

endinterface

// File: rtl/rgmii_phy_if.sv
module rgmii_phy_if import rgmii_pkg::*; #(
    parameter bit                   IN_PHASE_TX_CLK = 1'b0,
    parameter bit                   USE_IDELAY      = 1'b0,
    parameter logic [TAP_WIDTH-1:0] IDELAY_VALUE    = '0,
    parameter int                   STAT_WIDTH      = 16
) (
    // gmii transmit from the MAC
    input  logic                  gmii_tx_clk_i,
    input  logic                  gmii_tx_clk90_i,
    input  logic                  rst_i,
    input  logic [7:0]            gmii_txd_i,
    input  logic                  gmii_tx_en_i,
    input  logic                  gmii_tx_er_i,
    // rgmii pins towards the PHY
    output logic [3:0]            rgmii_txd_o,
    output logic                  rgmii_tx_ctl_o,
    output logic                  rgmii_tx_clk_o,
    input  logic [3:0]            rgmii_rxd_i,
    input  logic                  rgmii_rx_ctl_i,
    input  logic                  rgmii_rx_clk_i,
    // gmii receive to the MAC
    output logic                  gmii_rx_clk_o,
    output logic [7:0]            gmii_rxd_o,
    output logic                  gmii_rx_dv_o,
    output logic                  gmii_rx_er_o,
    // receive status
    output logic                  link_up_o,
    output link_speed_t           link_speed_o,
    output logic                  full_duplex_o,
    output logic [STAT_WIDTH-1:0] rx_frames_o,
    output logic [STAT_WIDTH-1:0] rx_error_frames_o,
    // delay taps, clk_div domain
    input  logic                  clk_div_i,
    input  logic                  idelay_load_i,
    input  logic [TAP_WIDTH-1:0]  idelay_value_i,
    output logic [TAP_WIDTH-1:0]  idelay_value_ctl_o,
    output logic [TAP_WIDTH-1:0]  idelay_value_data_o
);

    // per-lane pin wires, ctl on the top index
    logic [NUM_LANES-1:0] tx_pins;
    logic [NUM_LANES-1:0] rx_pins;
    // only ctl and lane 0 readback leave the block
    logic [TAP_WIDTH-1:0] tap_rb [NUM_LANES];

    rgmii_lane_if lanes ();

    rgmii_tx_encode #(
        .IN_PHASE_TX_CLK (IN_PHASE_TX_CLK)
    ) u_tx_encode (
        .gmii_tx_clk_i   (gmii_tx_clk_i),
        .gmii_tx_clk90_i (gmii_tx_clk90_i),
        .rst_i           (rst_i),
        .gmii_txd_i      (gmii_txd_i),
        .gmii_tx_en_i    (gmii_tx_en_i),
        .gmii_tx_er_i    (gmii_tx_er_i),
        .lanes           (lanes.enc),
        .rgmii_tx_clk_o  (rgmii_tx_clk_o)
    );

    // four data lanes plus ctl, all alike
    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_lane
        rgmii_ddr_lane #(
            .LANE         (g),
            .USE_IDELAY   (USE_IDELAY),
            .IDELAY_VALUE (IDELAY_VALUE)
        ) u_lane (
            .tx_clk_i    (gmii_tx_clk_i),
            .rx_clk_i    (rgmii_rx_clk_i),
            .clk_div_i   (clk_div_i),
            .rst_i       (rst_i),
            .lanes       (lanes.lane),
            .pin_o       (tx_pins[g]),
            .pin_i       (rx_pins[g]),
            .tap_load_i  (idelay_load_i),
            .tap_value_i (idelay_value_i),
            .tap_value_o (tap_rb[g])
        );
    end

    assign rgmii_txd_o    = tx_pins[CTL_LANE-1:0];
    assign rgmii_tx_ctl_o = tx_pins[CTL_LANE];
    assign rx_pins        = {rgmii_rx_ctl_i, rgmii_rxd_i};

    rgmii_rx_decode #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_rx_decode (
        .rx_clk_i          (rgmii_rx_clk_i),
        .rst_i             (rst_i),
        .lanes             (lanes.dec),
        .gmii_rxd_o        (gmii_rxd_o),
        .gmii_rx_dv_o      (gmii_rx_dv_o),
        .gmii_rx_er_o      (gmii_rx_er_o),
        .link_up_o         (link_up_o),
        .link_speed_o      (link_speed_o),
        .full_duplex_o     (full_duplex_o),
        .rx_frames_o       (rx_frames_o),
        .rx_error_frames_o (rx_error_frames_o)
    );

    // rx clock goes straight through to the MAC
    assign gmii_rx_clk_o = rgmii_rx_clk_i;

    assign idelay_value_ctl_o  = tap_rb[CTL_LANE];
    assign idelay_value_data_o = tap_rb[0];

endmodule

// File: rtl/rgmii_pkg.sv
package rgmii_pkg;

    // lanes 0..3 carry nibble bits, the last one carries ctl
    localparam int NUM_LANES = 5;
    localparam int CTL_LANE  = 4;

    // frame delimiters as seen on the rebuilt gmii byte
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // width of the delay tap counter value
    localparam int TAP_WIDTH = 5;

    // in-band status speed field, bits 2:1 of the rx nibble
    typedef enum logic [1:0] {
        SPEED_10   = 2'b00,
        SPEED_100  = 2'b01,
        SPEED_1000 = 2'b10,
        SPEED_RSVD = 2'b11
    } link_speed_t;

    // receive frame tracking
    typedef enum logic [1:0] {
        RX_IDLE     = 2'b00,
        RX_PREAMBLE = 2'b01,
        RX_FRAME    = 2'b10,
        RX_DISCARD  = 2'b11
    } rx_state_t;

endpackage

// File: rtl/rgmii_rx_decode.sv
module rgmii_rx_decode import rgmii_pkg::*; #(
    parameter int STAT_WIDTH = 16
) (
    input  logic                  rx_clk_i,
    input  logic                  rst_i,
    rgmii_lane_if.dec             lanes,
    output logic [7:0]            gmii_rxd_o,
    output logic                  gmii_rx_dv_o,
    output logic                  gmii_rx_er_o,
    output logic                  link_up_o,
    output link_speed_t           link_speed_o,
    output logic                  full_duplex_o,
    output logic [STAT_WIDTH-1:0] rx_frames_o,
    output logic [STAT_WIDTH-1:0] rx_error_frames_o
);

    // frame tracking
    rx_state_t state_q;
    rx_state_t state_d;
    logic      frame_done;

    // er seen anywhere since dv rose
    logic      err_seen_q;
    logic      err_seen_d;

    // counters
    logic [STAT_WIDTH-1:0] frames_q;
    logic [STAT_WIDTH-1:0] err_frames_q;
    // sticky, frame counter rolled over at least once
    logic                  frames_wrapped_q;

    // in-band status
    logic        link_up_q;
    link_speed_t speed_q;
    logic        duplex_q;

    // byte is fall nibble over rise nibble, no extra delay
    assign gmii_rxd_o   = {lanes.rx_fall[CTL_LANE-1:0], lanes.rx_rise[CTL_LANE-1:0]};
    assign gmii_rx_dv_o = lanes.rx_rise[CTL_LANE];
    // fall half of ctl carries dv xor er
    assign gmii_rx_er_o = lanes.rx_rise[CTL_LANE] ^ lanes.rx_fall[CTL_LANE];

    // next state
    always_comb
    begin
        state_d    = state_q;
        frame_done = 1'b0;
        case (state_q)
            RX_IDLE:
            begin
                if (gmii_rx_dv_o)
                begin
                    state_d = RX_PREAMBLE;
                end
            end
            RX_PREAMBLE:
            begin
                // frame dropped inside preamble, nothing counted
                if (!gmii_rx_dv_o)
                begin
                    state_d = RX_IDLE;
                end
                else if (gmii_rxd_o == SFD_BYTE)
                begin
                    state_d = RX_FRAME;
                end
                else if (gmii_rxd_o != PREAMBLE_BYTE)
                begin
                    state_d = RX_DISCARD;
                end
            end
            RX_FRAME:
            begin
                if (!gmii_rx_dv_o)
                begin
                    state_d    = RX_IDLE;
                    frame_done = 1'b1;
                end
            end
            RX_DISCARD:
            begin
                // bad delimiter, wait out the rest
                if (!gmii_rx_dv_o)
                begin
                    state_d = RX_IDLE;
                end
            end
            default:
            begin
                state_d = RX_IDLE;
            end
        endcase
    end

    // restart tracking at each new frame
    assign err_seen_d = (state_q == RX_IDLE) ? (gmii_rx_dv_o & gmii_rx_er_o)
                                             : (err_seen_q | (gmii_rx_dv_o & gmii_rx_er_o));

    always_ff @(posedge rx_clk_i)
    begin
        if (rst_i)
        begin
            state_q          <= RX_IDLE;
            err_seen_q       <= 1'b0;
            frames_q         <= '0;
            err_frames_q     <= '0;
            frames_wrapped_q <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            err_seen_q <= err_seen_d;
            // counters wrap
            if (frame_done)
            begin
                frames_q <= frames_q + 1'b1;
                if (&frames_q)
                begin
                    frames_wrapped_q <= 1'b1;
                end
                if (err_seen_q)
                begin
                    err_frames_q <= err_frames_q + 1'b1;
                end
            end
        end
    end

    // status nibble is only valid between frames with er low
    // bit 0 link, bits 2:1 speed, bit 3 duplex
    always_ff @(posedge rx_clk_i)
    begin
        if (rst_i)
        begin
            link_up_q <= 1'b0;
            speed_q   <= SPEED_10;
            duplex_q  <= 1'b0;
        end
        else if (!gmii_rx_dv_o && !gmii_rx_er_o)
        begin
            link_up_q <= lanes.rx_rise[0];
            speed_q   <= link_speed_t'(lanes.rx_rise[2:1]);
            duplex_q  <= lanes.rx_rise[3];
        end
    end

    assign link_up_o         = link_up_q;
    assign link_speed_o      = speed_q;
    assign full_duplex_o     = duplex_q;
    assign rx_frames_o       = frames_q;
    assign rx_error_frames_o = err_frames_q;

    // counters only move right after dv drops
    a_count_on_dv_fall : assert property (
        @(posedge rx_clk_i) disable iff (rst_i)
        ($changed(frames_q) || $changed(err_frames_q)) |-> $past($fell(gmii_rx_dv_o))
    );

    // error frames are a subset of all frames until rollover
    a_err_le_frames : assert property (
        @(posedge rx_clk_i) disable iff (rst_i)
        !frames_wrapped_q |-> (err_frames_q <= frames_q)
    );

endmodule

// File: rtl/rgmii_tx_encode.sv
module rgmii_tx_encode import rgmii_pkg::*; #(
    parameter bit IN_PHASE_TX_CLK = 1'b0
) (
    input  logic         gmii_tx_clk_i,
    input  logic         gmii_tx_clk90_i,
    input  logic         rst_i,
    input  logic [7:0]   gmii_txd_i,
    input  logic         gmii_tx_en_i,
    input  logic         gmii_tx_er_i,
    rgmii_lane_if.enc    lanes,
    output logic         rgmii_tx_clk_o
);

    // registered gmii inputs
    logic [7:0] txd_q;
    logic       tx_en_q;
    logic       tx_er_q;

    // sample the byte stream on the rising edge
    always_ff @(posedge gmii_tx_clk_i)
    begin
        if (rst_i)
        begin
            txd_q   <= 8'h00;
            tx_en_q <= 1'b0;
            tx_er_q <= 1'b0;
        end
        else
        begin
            txd_q   <= gmii_txd_i;
            tx_en_q <= gmii_tx_en_i;
            tx_er_q <= gmii_tx_er_i;
        end
    end

    // low nibble and en in the first half of the cycle
    assign lanes.tx_rise[CTL_LANE-1:0] = txd_q[3:0];
    assign lanes.tx_rise[CTL_LANE]     = tx_en_q;

    // high nibble in the second half
    assign lanes.tx_fall[CTL_LANE-1:0] = txd_q[7:4];
    // second ctl half encodes er as en xor er
    assign lanes.tx_fall[CTL_LANE]     = tx_en_q ^ tx_er_q;

    // forwarded clock, high during the first half of its source cycle
    // 90-degree copy centres the edge in the data eye
    // some PHYs add their own skew and want the in-phase clock
    assign rgmii_tx_clk_o = IN_PHASE_TX_CLK ? gmii_tx_clk_i : gmii_tx_clk90_i;

    // ctl pin must stay defined once out of reset
    a_tx_ctl_known : assert property (
        @(posedge gmii_tx_clk_i) disable iff (rst_i)
        !$isunknown(lanes.tx_rise[CTL_LANE])
    );

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 10
) (
    output logic clk_o,
    output logic clk90_o
);

    // main tx clock, first rising edge half a period in
    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // same clock shifted by a quarter period
    initial
    begin
        clk90_o = 1'b0;
        #(PERIOD / 4.0);
        forever #(PERIOD / 2) clk90_o = ~clk90_o;
    end

endmodule

// File: sim/tb_rgmii_phy_if.sv
module tb_rgmii_phy_if import rgmii_pkg::*; ();

    localparam logic [TAP_WIDTH-1:0] TAP_RESET = 5'd7;

    logic                 clk;
    logic                 clk90;
    logic                 rst;
    logic [7:0]           gmii_txd;
    logic                 gmii_tx_en;
    logic                 gmii_tx_er;
    // loopback nets, tx pins feed the rx pins
    logic [3:0]           rgmii_d;
    logic                 rgmii_ctl;
    logic                 rgmii_clk;
    logic                 gmii_rx_clk;
    logic [7:0]           gmii_rxd;
    logic                 gmii_rx_dv;
    logic                 gmii_rx_er;
    logic                 link_up;
    link_speed_t          link_speed;
    logic                 full_duplex;
    logic [15:0]          rx_frames;
    logic [15:0]          rx_error_frames;
    logic                 idelay_load;
    logic [TAP_WIDTH-1:0] idelay_value;
    logic [TAP_WIDTH-1:0] tap_ctl;
    logic [TAP_WIDTH-1:0] tap_data;

    integer               seed;
    int                   error_count;
    int                   test_count;
    int                   failed_tests;
    int                   errors_at_start;
    // {er, byte} for every byte sent with tx_en
    logic [8:0]           exp_q [$];
    logic [8:0]           cur_exp;
    logic                 cur_exp_valid;

    tb_clock_gen #(.PERIOD (10)) u_clock_gen (.clk_o (clk), .clk90_o (clk90));

    rgmii_phy_if #(
        .IN_PHASE_TX_CLK (1'b0),
        .USE_IDELAY      (1'b1),
        .IDELAY_VALUE    (TAP_RESET),
        .STAT_WIDTH      (16)
    ) UUT (
        .gmii_tx_clk_i       (clk),
        .gmii_tx_clk90_i     (clk90),
        .rst_i               (rst),
        .gmii_txd_i          (gmii_txd),
        .gmii_tx_en_i        (gmii_tx_en),
        .gmii_tx_er_i        (gmii_tx_er),
        .rgmii_txd_o         (rgmii_d),
        .rgmii_tx_ctl_o      (rgmii_ctl),
        .rgmii_tx_clk_o      (rgmii_clk),
        .rgmii_rxd_i         (rgmii_d),
        .rgmii_rx_ctl_i      (rgmii_ctl),
        .rgmii_rx_clk_i      (rgmii_clk),
        .gmii_rx_clk_o       (gmii_rx_clk),
        .gmii_rxd_o          (gmii_rxd),
        .gmii_rx_dv_o        (gmii_rx_dv),
        .gmii_rx_er_o        (gmii_rx_er),
        .link_up_o           (link_up),
        .link_speed_o        (link_speed),
        .full_duplex_o       (full_duplex),
        .rx_frames_o         (rx_frames),
        .rx_error_frames_o   (rx_error_frames),
        .clk_div_i           (clk),
        .idelay_load_i       (idelay_load),
        .idelay_value_i      (idelay_value),
        .idelay_value_ctl_o  (tap_ctl),
        .idelay_value_data_o (tap_data)
    );

    // rx outputs are stable at the falling edge, take the next expected byte there
    always @(negedge gmii_rx_clk)
    begin
        if (rst)
        begin
            cur_exp_valid <= 1'b0;
        end
        else if (gmii_rx_dv)
        begin
            if (exp_q.size() != 0)
            begin
                cur_exp       <= exp_q.pop_front();
                cur_exp_valid <= 1'b1;
            end
            else
            begin
                cur_exp_valid <= 1'b0;
            end
        end
    end

    // looped back bytes arrive in order
    a_rx_byte_order : assert property (
        @(posedge gmii_rx_clk) disable iff (rst)
        gmii_rx_dv |-> (cur_exp_valid && gmii_rxd == cur_exp[7:0])
    ) else
    begin
        error_count++;
        $display("ERROR: %0t rx byte %02h, expected %02h", $time,
                 $sampled(gmii_rxd), $sampled(cur_exp[7:0]));
    end

    // er only on the bytes sent with tx_er
    a_rx_er_match : assert property (
        @(posedge gmii_rx_clk) disable iff (rst)
        gmii_rx_dv |-> (gmii_rx_er == cur_exp[8])
    ) else
    begin
        error_count++;
        $display("ERROR: %0t rx er %0b on byte %02h, expected %0b", $time,
                 $sampled(gmii_rx_er), $sampled(gmii_rxd), $sampled(cur_exp[8]));
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
        assert (got === want)
        else
        begin
            error_count++;
            $display("ERROR: %0t %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_at_start)
        begin
            $display("test %0d %s: passed", test_count, name);
        end
        else
        begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_count, name,
                     error_count - errors_at_start);
        end
    endtask

    // idle bytes carry the status nibble twice
    task automatic drive_idle(input int cycles, input logic [3:0] pat, input logic er);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            gmii_txd   = {pat, pat};
            gmii_tx_en = 1'b0;
            gmii_tx_er = er;
        end
    endtask

    task automatic drive_byte(input logic [8:0] b);
        @(posedge clk);
        #1;
        gmii_txd   = b[7:0];
        gmii_tx_en = 1'b1;
        gmii_tx_er = b[8];
        exp_q.push_back(b);
    endtask

    // polls dv or er once per cycle, inputs held
    task automatic wait_rx_ctl(input bit watch_er, input logic level, input int limit);
        int n;
        n = 0;
        while (((watch_er ? gmii_rx_er : gmii_rx_dv) !== level) && n < limit)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if ((watch_er ? gmii_rx_er : gmii_rx_dv) !== level)
        begin
            error_count++;
            $display("timeout: %s did not go %s within %0d cycles",
                     watch_er ? "gmii_rx_er_o" : "gmii_rx_dv_o", level ? "high" : "low", limit);
        end
    endtask

    // seven preamble bytes, a delimiter, then random payload
    task automatic send_frame(input logic [7:0] delim, input int payload_len,
                              input logic [31:0] er_mask);
        logic [8:0]  frame [0:63];
        logic [31:0] rnd;
        int          len;
        int          i;
        len = 0;
        for (i = 0; i < 7; i++)
        begin
            frame[len] = {1'b0, PREAMBLE_BYTE};
            len++;
        end
        frame[len] = {1'b0, delim};
        len++;
        for (i = 0; i < payload_len; i++)
        begin
            rnd        = $random(seed);
            frame[len] = {er_mask[i], rnd[7:0]};
            len++;
        end
        fork
            begin
                for (i = 0; i < len; i++)
                begin
                    drive_byte(frame[i]);
                end
                drive_idle(1, 4'h0, 1'b0);
            end
            wait_rx_ctl(1'b0, 1'b1, 20);
        join
        wait_rx_ctl(1'b0, 1'b0, 20);
        // counters land one rx cycle after dv drops
        drive_idle(3, 4'h0, 1'b0);
        check_value("bytes not looped back", exp_q.size(), 0);
    endtask

    // status follows the idle nibble, given a few cycles of pipeline
    task automatic wait_status(input logic [3:0] pat, input int limit);
        int n;
        n = 0;
        while ({full_duplex, link_speed, link_up} !== pat && n < limit)
        begin
            drive_idle(1, pat, 1'b0);
            n++;
        end
        check_value("link_up_o", link_up, pat[0]);
        check_value("link_speed_o", link_speed, pat[2:1]);
        check_value("full_duplex_o", full_duplex, pat[3]);
    endtask

    task automatic load_tap(input logic [TAP_WIDTH-1:0] value);
        @(posedge clk);
        #1;
        idelay_load  = 1'b1;
        idelay_value = value;
        @(posedge clk);
        #1;
        idelay_load = 1'b0;
        check_value("idelay_value_ctl_o", tap_ctl, value);
        check_value("idelay_value_data_o", tap_data, value);
    endtask

    initial
    begin
        logic [15:0] frames_before;
        logic [15:0] errs_before;
        logic [15:0] pats;
        logic [3:0]  pat;
        logic [31:0] rnd;
        int          i;
        seed            = 32'h61ac_5f83;
        error_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        errors_at_start = 0;
        cur_exp         = '0;
        cur_exp_valid   = 1'b0;
        rst             = 1'b1;
        gmii_txd        = 8'h00;
        gmii_tx_en      = 1'b0;
        gmii_tx_er      = 1'b0;
        idelay_load     = 1'b0;
        idelay_value    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        check_value("rgmii_tx_ctl_o", rgmii_ctl, 1'b0);
        check_value("gmii_rx_dv_o", gmii_rx_dv, 1'b0);
        check_value("gmii_rx_er_o", gmii_rx_er, 1'b0);
        check_value("link_up_o", link_up, 1'b0);
        check_value("link_speed_o", link_speed, SPEED_10);
        check_value("full_duplex_o", full_duplex, 1'b0);
        check_value("rx_frames_o", rx_frames, 0);
        check_value("rx_error_frames_o", rx_error_frames, 0);
        check_value("idelay_value_ctl_o", tap_ctl, TAP_RESET);
        check_value("idelay_value_data_o", tap_data, TAP_RESET);
        // rx clock passes straight through to the MAC side
        check_value("gmii_rx_clk_o", gmii_rx_clk, rgmii_clk);
        report_test("reset state");

        start_test();
        drive_idle(4, 4'h0, 1'b0);
        frames_before = rx_frames;
        errs_before   = rx_error_frames;
        send_frame(SFD_BYTE, 24, 32'h0);
        check_value("rx_frames_o", rx_frames, frames_before + 1);
        check_value("rx_error_frames_o", rx_error_frames, errs_before);
        report_test("good frame");

        start_test();
        frames_before = rx_frames;
        errs_before   = rx_error_frames;
        // er on payload bytes 1, 4 and 10
        send_frame(SFD_BYTE, 16, 32'h0000_0412);
        check_value("rx_frames_o", rx_frames, frames_before + 1);
        check_value("rx_error_frames_o", rx_error_frames, errs_before + 1);
        report_test("error frame");

        start_test();
        // lowest nibble first, last one left in place
        pats = {4'b1011, 4'b0111, 4'b1101, 4'b0001};
        for (i = 0; i < 4; i++)
        begin
            pat = pats[4*i +: 4];
            wait_status(pat, 20);
        end
        frames_before = rx_frames;
        errs_before   = rx_error_frames;
        // er alone, nibble changed underneath must not reach status
        drive_idle(1, 4'b0000, 1'b1);
        wait_rx_ctl(1'b1, 1'b1, 20);
        drive_idle(3, 4'b0000, 1'b1);
        check_value("gmii_rx_dv_o", gmii_rx_dv, 1'b0);
        check_value("gmii_rx_er_o", gmii_rx_er, 1'b1);
        check_value("link_up_o", link_up, pat[0]);
        check_value("link_speed_o", link_speed, pat[2:1]);
        check_value("full_duplex_o", full_duplex, pat[3]);
        check_value("rx_frames_o", rx_frames, frames_before);
        check_value("rx_error_frames_o", rx_error_frames, errs_before);
        drive_idle(4, pat, 1'b0);
        report_test("in-band status");

        start_test();
        drive_idle(4, 4'h0, 1'b0);
        frames_before = rx_frames;
        errs_before   = rx_error_frames;
        send_frame(8'hA5, 12, 32'h0);
        check_value("rx_frames_o", rx_frames, frames_before);
        check_value("rx_error_frames_o", rx_error_frames, errs_before);
        report_test("bad delimiter");

        start_test();
        for (i = 0; i < 2; i++)
        begin
            rnd = $random(seed);
            load_tap(rnd[TAP_WIDTH-1:0]);
        end
        report_test("tap load");

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
